// ==== include/maze_consts.svh ====
`ifndef MAZE_CONSTS_SVH
`define MAZE_CONSTS_SVH

// Grid is square, one bit per cell.
`define MAZE_DIM 16

// Bits per coordinate, and per flat cell address.
`define COORD_W 4
`define ADDR_W 8

// Stack and FIFO depth.
`define PATH_DEPTH 256

// Bottom right corner.
`define GOAL_X 15
`define GOAL_Y 15

`endif

// ==== src/maze_pkg.sv ====
`include "maze_consts.svh"

package maze_pkg;

	// Fixed search order.
	typedef enum logic [1:0] {
		DIR_E = 2'd0,
		DIR_S = 2'd1,
		DIR_W = 2'd2,
		DIR_N = 2'd3
	} dir_t;

	typedef struct packed {
		logic [`COORD_W-1:0] y;
		logic [`COORD_W-1:0] x;
	} coord_t;

	// Row major, so the flat address is y * MAZE_DIM + x.
	typedef union packed {
		coord_t xy;
		logic [`ADDR_W-1:0] addr;
	} pos_t;

	typedef enum logic [3:0] {
		IDLE, LOAD, INIT_SEARCH, MAKE_WALL, CHECK_GOAL,
		PROBE, CHECK_WALL, PUSH_STEP, NEXT_DIR, POP_STACK,
		UNDO_STEP, DRAIN, DONE, SHOW, FAIL
	} state_t;

endpackage

// ==== src/maze_if.sv ====
`timescale 1ns/1ns

// Direction stack port.
interface stack_if;
	logic push;
	logic pop;
	maze_pkg::dir_t din;
	maze_pkg::dir_t dout;
	logic empty;

	modport ctrl (
		output push,
		output pop,
		output din,
		input empty
	);

	modport mem (
		input push,
		input pop,
		input din,
		output dout,
		output empty
	);
endinterface

// Replay FIFO port. din is tied to the stack top at the top level.
interface fifo_if;
	logic push;
	logic pop;
	maze_pkg::dir_t din;
	maze_pkg::dir_t dout;
	logic empty;

	modport ctrl (
		output push,
		output pop,
		input empty
	);

	modport mem (
		input push,
		input pop,
		input din,
		output dout,
		output empty
	);
endinterface

// ==== src/path_stack.sv ====
`timescale 1ns/1ns
`include "maze_consts.svh"

module path_stack #(
	parameter int DEPTH = `PATH_DEPTH
) (
	input logic CLK,
	input logic RST,
	stack_if.mem stk
);

	localparam int AW = $clog2(DEPTH);
	localparam int PW = $clog2(DEPTH + 1);

	maze_pkg::dir_t mem [DEPTH];
	logic [PW-1:0] sp;
	logic [PW-1:0] top_idx;

	// sp counts entries, the top sits one below.
	assign top_idx = sp - PW'(1);
	assign stk.dout = mem[top_idx[AW-1:0]];
	assign stk.empty = (sp == '0);

	always_ff @(posedge CLK) begin
		if (stk.push)
			mem[sp[AW-1:0]] <= stk.din;
	end

	always_ff @(posedge CLK) begin
		if (RST)
			sp <= '0;
		else if (stk.push)
			sp <= sp + PW'(1);
		else if (stk.pop)
			sp <= top_idx;
	end

endmodule

// ==== src/path_fifo.sv ====
`timescale 1ns/1ns
`include "maze_consts.svh"

module path_fifo #(
	parameter int DEPTH = `PATH_DEPTH
) (
	input logic CLK,
	input logic RST,
	fifo_if.mem fq
);

	localparam int AW = $clog2(DEPTH);
	localparam int PW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

	maze_pkg::dir_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [PW-1:0] count;

	assign fq.dout = mem[rd_ptr];
	assign fq.empty = (count == '0);

	always_ff @(posedge CLK) begin
		if (fq.push)
			mem[wr_ptr] <= fq.din;
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (fq.push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + AW'(1);
			if (fq.pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + AW'(1);
			case ({fq.push, fq.pop})
				2'b10: count <= count + PW'(1);
				2'b01: count <= count - PW'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== src/maze_datapath.sv ====
`timescale 1ns/1ns
`include "maze_consts.svh"

module maze_datapath (
	input logic CLK,
	input logic RST,
	input logic maze_bit,
	input logic loading,
	input logic clr_pos,
	input logic clr_dir,
	input logic step,
	input logic undo,
	input logic mark,
	input logic inc_dir,
	input logic load_dir,
	input maze_pkg::dir_t popped_dir,
	output maze_pkg::dir_t dir,
	output logic load_last,
	output logic wall_ahead,
	output logic at_goal,
	output logic dir_last
);

	localparam int CELLS = `MAZE_DIM * `MAZE_DIM;
	localparam logic [`COORD_W-1:0] COORD_MAX = `COORD_W'(`MAZE_DIM - 1);

	logic [CELLS-1:0] maze_mem;
	logic [`ADDR_W-1:0] load_cnt;
	maze_pkg::pos_t pos;
	maze_pkg::pos_t probe;
	maze_pkg::dir_t back_dir;

	function automatic maze_pkg::pos_t shift_pos(input maze_pkg::pos_t p, input maze_pkg::dir_t d);
		maze_pkg::pos_t q;
		q = p;
		case (d)
			maze_pkg::DIR_E: q.xy.x = p.xy.x + `COORD_W'(1);
			maze_pkg::DIR_S: q.xy.y = p.xy.y + `COORD_W'(1);
			maze_pkg::DIR_W: q.xy.x = p.xy.x - `COORD_W'(1);
			default: q.xy.y = p.xy.y - `COORD_W'(1);
		endcase
		return q;
	endfunction

	function automatic logic off_grid(input maze_pkg::pos_t p, input maze_pkg::dir_t d);
		case (d)
			maze_pkg::DIR_E: return p.xy.x == COORD_MAX;
			maze_pkg::DIR_S: return p.xy.y == COORD_MAX;
			maze_pkg::DIR_W: return p.xy.x == '0;
			default: return p.xy.y == '0;
		endcase
	endfunction

	// Opposite direction flips the upper bit.
	assign back_dir = maze_pkg::dir_t'(popped_dir ^ 2'b10);
	assign probe = shift_pos(pos, dir);

	assign load_last = (load_cnt == `ADDR_W'(CELLS - 1));
	assign at_goal = (pos.xy.x == `COORD_W'(`GOAL_X)) && (pos.xy.y == `COORD_W'(`GOAL_Y));
	assign dir_last = (dir == maze_pkg::DIR_N);
	// While clearing the position the start cell is probed.
	assign wall_ahead = clr_pos ? maze_mem[0] : (off_grid(pos, dir) || maze_mem[probe.addr]);

	always_ff @(posedge CLK) begin
		if (loading)
			maze_mem[load_cnt] <= maze_bit;
		else if (mark)
			maze_mem[pos.addr] <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			load_cnt <= '0;
			pos <= '0;
			dir <= maze_pkg::DIR_E;
		end else begin
			if (loading)
				load_cnt <= load_cnt + `ADDR_W'(1);
			if (clr_pos)
				pos <= '0;
			else if (step)
				pos <= probe;
			else if (undo)
				pos <= shift_pos(pos, back_dir);
			if (clr_dir)
				dir <= maze_pkg::DIR_E;
			else if (load_dir)
				dir <= popped_dir;
			else if (inc_dir)
				dir <= maze_pkg::dir_t'(dir + 2'd1);
		end
	end

endmodule

// ==== src/maze_controller.sv ====
`timescale 1ns/1ns

module maze_controller (
	input logic CLK,
	input logic RST,
	input logic start,
	input logic run,
	input logic load_last,
	input logic wall_ahead,
	input logic at_goal,
	input logic dir_last,
	input maze_pkg::dir_t dir,
	output logic loading,
	output logic clr_pos,
	output logic clr_dir,
	output logic step,
	output logic undo,
	output logic mark,
	output logic inc_dir,
	output logic load_dir,
	output logic done,
	output logic fail,
	output logic move,
	stack_if.ctrl stk,
	fifo_if.ctrl fq
);

	maze_pkg::state_t state;
	maze_pkg::state_t next_state;

	always_ff @(posedge CLK) begin
		if (RST)
			state <= maze_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		loading = 1'b0;
		clr_pos = 1'b0;
		clr_dir = 1'b0;
		step = 1'b0;
		undo = 1'b0;
		mark = 1'b0;
		inc_dir = 1'b0;
		load_dir = 1'b0;
		done = 1'b0;
		fail = 1'b0;
		move = 1'b0;
		stk.push = 1'b0;
		stk.pop = 1'b0;
		stk.din = dir;
		fq.push = 1'b0;
		fq.pop = 1'b0;
		case (state)
			maze_pkg::IDLE: begin
				if (start)
					next_state = maze_pkg::LOAD;
			end
			maze_pkg::LOAD: begin
				loading = 1'b1;
				// Flush a path that was never replayed.
				fq.pop = !fq.empty;
				if (load_last)
					next_state = maze_pkg::INIT_SEARCH;
			end
			maze_pkg::INIT_SEARCH: begin
				// wall_ahead shows the start cell here.
				clr_pos = 1'b1;
				clr_dir = 1'b1;
				next_state = wall_ahead ? maze_pkg::FAIL : maze_pkg::MAKE_WALL;
			end
			maze_pkg::MAKE_WALL: begin
				mark = 1'b1;
				next_state = maze_pkg::CHECK_GOAL;
			end
			maze_pkg::CHECK_GOAL: begin
				next_state = at_goal ? maze_pkg::DRAIN : maze_pkg::PROBE;
			end
			maze_pkg::PROBE: begin
				next_state = maze_pkg::CHECK_WALL;
			end
			maze_pkg::CHECK_WALL: begin
				if (!wall_ahead)
					next_state = maze_pkg::PUSH_STEP;
				else if (dir_last)
					next_state = maze_pkg::POP_STACK;
				else
					next_state = maze_pkg::NEXT_DIR;
			end
			maze_pkg::PUSH_STEP: begin
				stk.push = 1'b1;
				step = 1'b1;
				clr_dir = 1'b1;
				next_state = maze_pkg::MAKE_WALL;
			end
			maze_pkg::NEXT_DIR: begin
				inc_dir = 1'b1;
				next_state = maze_pkg::PROBE;
			end
			maze_pkg::POP_STACK: begin
				if (stk.empty) begin
					next_state = maze_pkg::FAIL;
				end else begin
					// Step back while the top entry is still visible.
					load_dir = 1'b1;
					undo = 1'b1;
					next_state = maze_pkg::UNDO_STEP;
				end
			end
			maze_pkg::UNDO_STEP: begin
				stk.pop = 1'b1;
				if (dir_last) begin
					next_state = maze_pkg::POP_STACK;
				end else begin
					inc_dir = 1'b1;
					next_state = maze_pkg::PROBE;
				end
			end
			maze_pkg::DRAIN: begin
				if (stk.empty) begin
					next_state = maze_pkg::DONE;
				end else begin
					stk.pop = 1'b1;
					fq.push = 1'b1;
				end
			end
			maze_pkg::DONE: begin
				done = 1'b1;
				if (start)
					next_state = maze_pkg::LOAD;
				else if (run && !fq.empty)
					next_state = maze_pkg::SHOW;
			end
			maze_pkg::SHOW: begin
				move = !fq.empty;
				fq.pop = !fq.empty;
				if (fq.empty)
					next_state = maze_pkg::DONE;
			end
			maze_pkg::FAIL: begin
				fail = 1'b1;
				if (start)
					next_state = maze_pkg::LOAD;
			end
			default: next_state = maze_pkg::IDLE;
		endcase
	end

endmodule

// ==== src/maze_solver_top.sv ====
`timescale 1ns/1ns
`include "maze_consts.svh"

module maze_solver_top (
	input logic CLK,
	input logic RST,
	input logic start,
	input logic run,
	input logic maze_bit,
	output logic load,
	output logic done,
	output logic fail,
	output logic move,
	output logic [1:0] move_dir
);

	logic clr_pos;
	logic clr_dir;
	logic step;
	logic undo;
	logic mark;
	logic inc_dir;
	logic load_dir;
	logic load_last;
	logic wall_ahead;
	logic at_goal;
	logic dir_last;
	maze_pkg::dir_t dir;

	stack_if stk_bus();
	fifo_if fq_bus();

	// Draining copies the stack top straight into the FIFO.
	assign fq_bus.din = stk_bus.dout;
	assign move_dir = fq_bus.dout;

	maze_controller u_ctrl (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.load_last(load_last), .wall_ahead(wall_ahead), .at_goal(at_goal),
		.dir_last(dir_last), .dir(dir), .loading(load), .clr_pos(clr_pos),
		.clr_dir(clr_dir), .step(step), .undo(undo), .mark(mark), .inc_dir(inc_dir),
		.load_dir(load_dir), .done(done), .fail(fail), .move(move),
		.stk(stk_bus.ctrl), .fq(fq_bus.ctrl)
	);

	maze_datapath u_dp (
		.CLK(CLK), .RST(RST), .maze_bit(maze_bit), .loading(load),
		.clr_pos(clr_pos), .clr_dir(clr_dir), .step(step), .undo(undo), .mark(mark),
		.inc_dir(inc_dir), .load_dir(load_dir), .popped_dir(stk_bus.dout), .dir(dir),
		.load_last(load_last), .wall_ahead(wall_ahead), .at_goal(at_goal),
		.dir_last(dir_last)
	);

	path_stack #(.DEPTH(`PATH_DEPTH)) u_stack (.CLK(CLK), .RST(RST), .stk(stk_bus.mem));

	path_fifo #(.DEPTH(`PATH_DEPTH)) u_fifo (.CLK(CLK), .RST(RST), .fq(fq_bus.mem));

endmodule

// ==== tb/maze_solver_assertions.sv ====
`timescale 1ns/1ns

module maze_solver_assertions (
	input logic CLK,
	input logic RST,
	input maze_pkg::state_t state,
	input logic move,
	input logic done,
	input logic fail,
	input logic load,
	input logic stk_push,
	input logic stk_pop,
	input logic fq_push,
	input logic fq_pop
);

	int load_run;

	// Completed load cycles in the current burst.
	always_ff @(posedge CLK) begin
		if (RST)
			load_run <= 0;
		else if (load)
			load_run <= load_run + 1;
		else
			load_run <= 0;
	end

	assert property (@(posedge CLK) disable iff (RST) move |-> state == maze_pkg::SHOW)
		else $error("move high outside SHOW");

	assert property (@(posedge CLK) disable iff (RST) !(done && fail))
		else $error("done and fail high together");

	assert property (@(posedge CLK) disable iff (RST) !(stk_push && stk_pop))
		else $error("stack push and pop in one cycle");

	assert property (@(posedge CLK) disable iff (RST) !(fq_push && fq_pop))
		else $error("FIFO push and pop in one cycle");

	assert property (@(posedge CLK) disable iff (RST) load_run <= 256)
		else $error("load longer than 256 cycles");

endmodule

// ==== tb/maze_solver_tb.sv ====
`timescale 1ns/1ns
`include "maze_consts.svh"

module maze_solver_tb;

	localparam int DIM = `MAZE_DIM;
	localparam int CELLS = DIM * DIM;
	localparam int SEARCH_BOUND = 256 + 4 * 256 * 4 + 256;
	localparam int WAIT_LIMIT = SEARCH_BOUND + 64;
	localparam int RUNS = 27;
	localparam int WATCHDOG_NS = (RUNS * (SEARCH_BOUND + 2 * CELLS + 64) + 200) * 100;

	logic CLK;
	logic RST;
	logic start;
	logic run;
	logic maze_bit;
	logic load;
	logic done;
	logic fail;
	logic move;
	logic [1:0] move_dir;

	int errors;
	int checks;
	int tests;
	int base_errors;
	int load_cycles;
	int wait_cycles;
	logic [31:0] rng;
	logic maze [CELLS];
	logic exp_found;
	maze_pkg::dir_t exp_path [$];
	maze_pkg::dir_t got_path [$];

	maze_solver_top DUT (
		.CLK(CLK), .RST(RST), .start(start), .run(run), .maze_bit(maze_bit),
		.load(load), .done(done), .fail(fail), .move(move), .move_dir(move_dir)
	);

	bind maze_controller maze_solver_assertions u_assert (
		.CLK(CLK), .RST(RST), .state(state), .move(move), .done(done),
		.fail(fail), .load(loading), .stk_push(stk.push), .stk_pop(stk.pop),
		.fq_push(fq.push), .fq_pop(fq.pop)
	);

	always #50 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int step_x(input int d);
		return (d == 0) ? 1 : ((d == 2) ? -1 : 0);
	endfunction

	function automatic int step_y(input int d);
		return (d == 1) ? 1 : ((d == 3) ? -1 : 0);
	endfunction

	task automatic check_dir(input string name, input maze_pkg::dir_t exp, input maze_pkg::dir_t act);
		checks++;
		if (exp !== act) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	// Same DFS as the hardware: fixed order, visited cells become walls.
	task automatic model_solve();
		logic grid [CELLS];
		maze_pkg::dir_t trail [$];
		int x;
		int y;
		int d;
		int nx;
		int ny;
		bit busy;
		exp_path.delete();
		exp_found = 1'b0;
		for (int i = 0; i < CELLS; i++)
			grid[i] = maze[i];
		busy = !grid[0];
		grid[0] = 1'b1;
		x = 0;
		y = 0;
		d = 0;
		while (busy) begin
			if (x == `GOAL_X && y == `GOAL_Y) begin
				exp_found = 1'b1;
				busy = 0;
			end else if (d < 4) begin
				nx = x + step_x(d);
				ny = y + step_y(d);
				if (nx >= 0 && nx < DIM && ny >= 0 && ny < DIM && !grid[ny * DIM + nx]) begin
					trail.push_back(maze_pkg::dir_t'(d[1:0]));
					x = nx;
					y = ny;
					grid[y * DIM + x] = 1'b1;
					d = 0;
				end else begin
					d++;
				end
			end else if (trail.size() == 0) begin
				busy = 0;
			end else begin
				d = int'(trail.pop_back());
				x = x - step_x(d);
				y = y - step_y(d);
				d++;
			end
		end
		// Drained top first.
		if (exp_found)
			for (int i = trail.size() - 1; i >= 0; i--)
				exp_path.push_back(trail[i]);
	endtask

	task automatic start_and_load();
		int guard;
		start = 1'b1;
		@(posedge CLK);
		#5;
		start = 1'b0;
		guard = 0;
		while (!load && guard < 8) begin
			@(posedge CLK);
			#5;
			guard++;
		end
		if (!load) begin
			$display("load never rose after start");
			errors++;
			return;
		end
		check_count("load_delay", 0, guard);
		check_flag("done", 1'b0, done);
		check_flag("fail", 1'b0, fail);
		load_cycles = 0;
		while (load && load_cycles < CELLS + 8) begin
			maze_bit = (load_cycles < CELLS) ? maze[load_cycles] : 1'b0;
			@(posedge CLK);
			#5;
			load_cycles++;
		end
		maze_bit = 1'b0;
		check_count("load_cycles", CELLS, load_cycles);
	endtask

	task automatic wait_result();
		wait_cycles = 0;
		while (!done && !fail && wait_cycles < WAIT_LIMIT) begin
			@(posedge CLK);
			#5;
			wait_cycles++;
		end
		if (!done && !fail) begin
			$display("search did not finish with done or fail in time");
			errors++;
		end
	endtask

	task automatic replay_path();
		int guard;
		int gaps;
		got_path.delete();
		gaps = 0;
		run = 1'b1;
		@(posedge CLK);
		#5;
		run = 1'b0;
		guard = 0;
		while (!done && !fail && guard < CELLS + 8) begin
			// Moves start the cycle after run and come back to back.
			if (move && guard != got_path.size())
				gaps++;
			if (move)
				got_path.push_back(maze_pkg::dir_t'(move_dir));
			@(posedge CLK);
			#5;
			guard++;
		end
		if (guard >= CELLS + 8) begin
			$display("replay did not return to done");
			errors++;
		end
		check_count("move_gaps", 0, gaps);
	endtask

	task automatic finish_and_compare();
		wait_result();
		model_solve();
		check_flag("done", exp_found, done);
		check_flag("fail", !exp_found, fail);
		replay_path();
		check_count("path_length", exp_path.size(), got_path.size());
		for (int i = 0; i < exp_path.size() && i < got_path.size(); i++)
			check_dir("move_dir", exp_path[i], got_path[i]);
	endtask

	task automatic solve_maze();
		start_and_load();
		finish_and_compare();
	endtask

	task automatic fill_open();
		for (int i = 0; i < CELLS; i++)
			maze[i] = 1'b0;
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == base_errors)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - base_errors);
		base_errors = errors;
	endtask

	task automatic test_open_maze();
		maze_pkg::dir_t want;
		fill_open();
		solve_maze();
		// Fifteen east then fifteen south, replayed last move first.
		check_count("open_path_length", 30, got_path.size());
		for (int i = 0; i < 30 && i < got_path.size(); i++) begin
			if (i < 15)
				want = maze_pkg::DIR_S;
			else
				want = maze_pkg::DIR_E;
			check_dir("move_dir", want, got_path[i]);
		end
		report_test("open_maze");
	endtask

	// Corridors every third row, gaps at alternating ends, one-cell spurs at x 8.
	task automatic test_serpentine();
		int k;
		for (int y = 0; y < DIM; y++) begin
			for (int x = 0; x < DIM; x++) begin
				k = y / 3;
				maze[y * DIM + x] = 1'b1;
				if (y % 3 == 0)
					maze[y * DIM + x] = 1'b0;
				else if (x == ((k % 2 == 0) ? DIM - 1 : 0))
					maze[y * DIM + x] = 1'b0;
				else if (y % 3 == 1 && x == 8)
					maze[y * DIM + x] = 1'b0;
			end
		end
		solve_maze();
		report_test("serpentine");
	endtask

	task automatic test_walled_goal();
		fill_open();
		maze[15 * DIM + 14] = 1'b1;
		maze[14 * DIM + 15] = 1'b1;
		solve_maze();
		check_count("moves_on_fail", 0, got_path.size());
		report_test("walled_goal");
	endtask

	task automatic test_wall_start();
		fill_open();
		maze[0] = 1'b1;
		start_and_load();
		wait_result();
		check_flag("fail", 1'b1, fail);
		check_flag("done", 1'b0, done);
		check_count("cycles_to_fail", 1, wait_cycles);
		// A new start clears fail, checked inside the load.
		maze[0] = 1'b0;
		solve_maze();
		check_flag("done", 1'b1, done);
		report_test("wall_start");
	endtask

	task automatic test_load_and_rerun();
		fill_open();
		maze[3] = 1'b1;
		solve_maze();
		replay_path();
		check_count("second_run_moves", 0, got_path.size());
		report_test("load_and_rerun");
	endtask

	task automatic test_random_mazes();
		for (int n = 0; n < 20; n++) begin
			for (int i = 0; i < CELLS; i++) begin
				rng = xorshift32(rng);
				maze[i] = ((rng % 100) < 30);
			end
			maze[0] = 1'b0;
			maze[CELLS - 1] = 1'b0;
			solve_maze();
		end
		report_test("random_mazes");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		CLK = 1'b0;
		RST = 1'b1;
		start = 1'b0;
		run = 1'b0;
		maze_bit = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		base_errors = 0;
		rng = 32'd31;
		repeat (16) @(posedge CLK);
		#5;
		RST = 1'b0;
		test_open_maze();
		test_serpentine();
		test_walled_goal();
		test_wall_start();
		test_load_and_rerun();
		test_random_mazes();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
src/maze_pkg.sv
src/maze_if.sv
src/path_stack.sv
src/path_fifo.sv
src/maze_datapath.sv
src/maze_controller.sv
src/maze_solver_top.sv
tb/maze_solver_assertions.sv
tb/maze_solver_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the maze solver testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module maze_solver_tb -o maze_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/maze_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB PASSED" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
